/* rtl/cfg_pkg.sv */
// configuration word channel types and register map
// word positions within one config packet

package cfg_pkg;

  //////////////////////////////////////////////////
  // config word channel
  //////////////////////////////////////////////////

  // payload width of one word on the config stream
  localparam int CFG_DWIDTH = 16;

  typedef logic [CFG_DWIDTH-1:0] cfg_word_t;  // one config word

  //////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////

  // position of a word inside the packet, two words max
  typedef logic [0:0] cfg_addr_t;

  localparam cfg_addr_t CFG_ADDR_GAIN   = 1'b0;  // first word, Q2.14 gain
  localparam cfg_addr_t CFG_ADDR_OFFSET = 1'b1;  // second word, signed offset

endpackage

/* rtl/sample_pkg.sv */
// sample and coefficient types
// scaler arithmetic widths and constants

package sample_pkg;

  localparam int SAMPLE_WIDTH   = 16;
  localparam int PRODUCT_WIDTH  = 2 * SAMPLE_WIDTH;             // full 16x16 product
  localparam int GAIN_FRAC_BITS = 14;                           // Q2.14 gain
  localparam int SUM_WIDTH      = PRODUCT_WIDTH - GAIN_FRAC_BITS; // 18, headroom for offset add

  typedef logic signed [SAMPLE_WIDTH-1:0]  sample_t;   // signed sample
  typedef logic signed [SAMPLE_WIDTH-1:0]  coef_t;     // gain in Q2.14
  typedef logic signed [PRODUCT_WIDTH-1:0] product_t;  // sample * gain
  typedef logic signed [SUM_WIDTH-1:0]     sum_t;      // shifted product + offset

  // power-up config: unity gain, no offset
  localparam coef_t   GAIN_RESET   = 16'sd16384;
  localparam sample_t OFFSET_RESET = 16'sd0;

  // saturation limits of the output
  localparam sample_t SAMPLE_MAX = 16'sh7fff;  // 32767
  localparam sample_t SAMPLE_MIN = 16'sh8000;  // -32768

endpackage

/* rtl/cdc_handshake.sv */
// req/ack handshake synchronizer, four flops each way
// carries one held data word from src_clk to dest_clk

`timescale 1ns/1ps
module cdc_handshake #(
  parameter int DWIDTH = 16
) (
  input  logic            src_clk,
  input  logic            src_reset,
  input  logic [DWIDTH:0] src_in,    // word plus one flag bit
  input  logic            src_send,
  output logic            src_rcv,

  input  logic            dest_clk,
  input  logic            dest_reset,
  input  logic            dest_ack,
  output logic            dest_req,
  output logic [DWIDTH:0] dest_out
);

  //////////////////////////////////////////////////
  // source domain
  //////////////////////////////////////////////////

  logic            src_req;   // registered send level, this is what crosses
  logic [DWIDTH:0] src_hold;  // word held for the whole handshake
  logic [3:0]      ack_sync;  // dest_ack synchronizer chain

  // grab the word on the rising edge of send
  always_ff @(posedge src_clk) begin
    if (src_send & ~src_req) begin
      src_hold <= src_in;
    end
  end

  always_ff @(posedge src_clk) begin
    if (src_reset) begin
      src_req  <= 1'b0;
      ack_sync <= '0;
    end else begin
      src_req  <= src_send;                     // also edge detect for capture
      ack_sync <= {ack_sync[2:0], dest_ack};    // ack back into src_clk
    end
  end

  assign src_rcv = ack_sync[3];  // ack seen on source side

  //////////////////////////////////////////////////
  // destination domain
  //////////////////////////////////////////////////

  logic [3:0] req_sync;  // src_req synchronizer chain

  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      req_sync <= '0;
      dest_req <= 1'b0;
    end else begin
      req_sync <= {req_sync[2:0], src_req};
      // follows the synced level, drops once src_send has fallen
      dest_req <= req_sync[3];
    end
  end

  // src_hold is stable while the request is up, so a plain load is safe
  // output word updates on the same edge that dest_req rises
  always_ff @(posedge dest_clk) begin
    if (req_sync[3] & ~dest_req) begin
      dest_out <= src_hold;
    end
  end

endmodule

/* rtl/axis_config_reg_cdc.sv */
// valid/ready/last config stream crossing from src_clk to dest_clk
// one word in flight, back-pressure on both sides

`timescale 1ns/1ps
module axis_config_reg_cdc #(
  parameter int DWIDTH = 16
) (
  input  logic              src_clk,
  input  logic              src_reset,
  input  logic [DWIDTH-1:0] src_data,
  input  logic              src_last,
  input  logic              src_valid,
  output logic              src_ready,

  input  logic              dest_clk,
  input  logic              dest_reset,
  output logic [DWIDTH-1:0] dest_data,
  output logic              dest_last,
  output logic              dest_valid,
  input  logic              dest_ready
);

  typedef enum logic [1:0] {
    SRC_IDLE,  // ready for a new word
    SRC_SEND,  // send high, waiting for ack
    SRC_WAIT   // send dropped, waiting for ack to clear
  } cdc_src_state_t;

  typedef enum logic [1:0] {
    DEST_IDLE,   // waiting for request
    DEST_VALID,  // beat presented downstream
    DEST_ACK     // ack high until request drops
  } cdc_dest_state_t;

  //////////////////////////////////////////////////
  // source side
  //////////////////////////////////////////////////

  cdc_src_state_t  src_state;
  logic [DWIDTH:0] src_packet;  // {last, data}
  logic            src_send;
  logic            src_rcv;

  assign src_ready = (src_state == SRC_IDLE);  // low for the full 4-phase cycle
  assign src_send  = (src_state == SRC_SEND);

  always_ff @(posedge src_clk) begin
    if (src_valid & src_ready) begin
      src_packet <= {src_last, src_data};  // last rides along as top bit
    end
  end

  always_ff @(posedge src_clk) begin
    if (src_reset) begin
      src_state <= SRC_IDLE;
    end else begin
      case (src_state)
        SRC_IDLE: if (src_valid) src_state <= SRC_SEND;
        SRC_SEND: if (src_rcv)   src_state <= SRC_WAIT;  // ack arrived, drop send
        SRC_WAIT: if (~src_rcv)  src_state <= SRC_IDLE;  // handshake closed
        default:                 src_state <= SRC_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // destination side
  //////////////////////////////////////////////////

  cdc_dest_state_t dest_state;
  logic [DWIDTH:0] dest_packet;
  logic            dest_req;
  logic            dest_ack;

  assign {dest_last, dest_data} = dest_packet;  // held by the synchronizer
  assign dest_valid = (dest_state == DEST_VALID);
  assign dest_ack   = (dest_state == DEST_ACK);

  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      dest_state <= DEST_IDLE;
    end else begin
      case (dest_state)
        DEST_IDLE:  if (dest_req)   dest_state <= DEST_VALID;
        DEST_VALID: if (dest_ready) dest_state <= DEST_ACK;   // single beat taken
        DEST_ACK:   if (~dest_req)  dest_state <= DEST_IDLE;  // src dropped send
        default:                    dest_state <= DEST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // synchronizer
  //////////////////////////////////////////////////

  cdc_handshake #(
    .DWIDTH(DWIDTH)
  ) sync0 (
    .src_clk    (src_clk),
    .src_reset  (src_reset),
    .src_in     (src_packet),
    .src_send   (src_send),
    .src_rcv    (src_rcv),
    .dest_clk   (dest_clk),
    .dest_reset (dest_reset),
    .dest_ack   (dest_ack),
    .dest_req   (dest_req),
    .dest_out   (dest_packet)
  );

endmodule

/* rtl/config_reg_bank.sv */
// config register bank: word counter, shadow gain/offset
// both made active together on the word flagged last

`timescale 1ns/1ps
module config_reg_bank (
  input  logic                dest_clk,
  input  logic                dest_reset,
  input  cfg_pkg::cfg_word_t  word_data,
  input  logic                word_last,
  input  logic                word_valid,
  output logic                word_ready,
  output sample_pkg::coef_t   gain,
  output sample_pkg::sample_t offset,
  output logic                config_update
);

  cfg_pkg::cfg_addr_t  word_idx;       // position of next word in packet
  logic                word_ovf;       // both words seen, ignore the rest
  logic                word_fire;
  logic                wr_gain;
  logic                wr_offset;
  sample_pkg::coef_t   shadow_gain;
  sample_pkg::sample_t shadow_offset;
  sample_pkg::coef_t   gain_next;      // shadow including this cycle's write
  sample_pkg::sample_t offset_next;

  assign word_ready = 1'b1;  // bank never stalls
  assign word_fire  = word_valid & word_ready;

  assign wr_gain   = word_fire & ~word_ovf & (word_idx == cfg_pkg::CFG_ADDR_GAIN);
  assign wr_offset = word_fire & ~word_ovf & (word_idx == cfg_pkg::CFG_ADDR_OFFSET);

  // the last word may itself be a shadow write, so commit from these
  assign gain_next   = wr_gain   ? sample_pkg::coef_t'(word_data)   : shadow_gain;
  assign offset_next = wr_offset ? sample_pkg::sample_t'(word_data) : shadow_offset;

  //////////////////////////////////////////////////
  // word counter
  //////////////////////////////////////////////////

  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      word_idx <= cfg_pkg::CFG_ADDR_GAIN;
      word_ovf <= 1'b0;
    end else if (word_fire) begin
      if (word_last) begin                                    // packet done, restart
        word_idx <= cfg_pkg::CFG_ADDR_GAIN;
        word_ovf <= 1'b0;
      end else if (word_idx == cfg_pkg::CFG_ADDR_OFFSET) begin
        word_ovf <= 1'b1;                                     // extra words dropped
      end else begin
        word_idx <= cfg_pkg::CFG_ADDR_OFFSET;
      end
    end
  end

  //////////////////////////////////////////////////
  // shadow and active registers
  //////////////////////////////////////////////////

  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      shadow_gain   <= sample_pkg::GAIN_RESET;
      shadow_offset <= sample_pkg::OFFSET_RESET;
      gain          <= sample_pkg::GAIN_RESET;
      offset        <= sample_pkg::OFFSET_RESET;
      config_update <= 1'b0;
    end else begin
      shadow_gain   <= gain_next;     // unwritten shadow keeps old value
      shadow_offset <= offset_next;
      config_update <= word_fire & word_last;
      if (word_fire & word_last) begin
        gain   <= gain_next;          // atomic commit, visible next cycle
        offset <= offset_next;
      end
    end
  end

endmodule

/* rtl/sample_scaler.sv */
// two-stage sample scaler: multiply by Q2.14 gain, shift, add offset
// and saturate to 16 bits

`timescale 1ns/1ps
module sample_scaler (
  input  logic                dest_clk,
  input  logic                dest_reset,
  input  sample_pkg::coef_t   gain,
  input  sample_pkg::sample_t offset,
  input  sample_pkg::sample_t sample_in,
  input  logic                sample_in_valid,
  output sample_pkg::sample_t sample_out,
  output logic                sample_out_valid
);

  sample_pkg::product_t prod_s1;     // full product
  sample_pkg::sample_t  offset_s1;   // offset travels with its sample
  logic                 valid_s1;
  sample_pkg::product_t prod_shift;  // product >>> frac bits
  sample_pkg::sum_t     sum_s2;      // 18 bit sum, cannot overflow
  sample_pkg::sample_t  sat_s2;

  //////////////////////////////////////////////////
  // stage 1: multiply
  //////////////////////////////////////////////////

  always_ff @(posedge dest_clk) begin
    if (sample_in_valid) begin
      // sign-extend both operands to full product width
      prod_s1   <= sample_pkg::product_t'(sample_in) * sample_pkg::product_t'(gain);
      offset_s1 <= offset;  // config as seen on the entry cycle
    end
  end

  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= sample_in_valid;
    end
  end

  //////////////////////////////////////////////////
  // stage 2: shift, offset add, saturate
  //////////////////////////////////////////////////

  always_comb begin
    prod_shift = prod_s1 >>> sample_pkg::GAIN_FRAC_BITS;  // arithmetic, floors
    // shifted product fits in 18 bits signed, so truncation is lossless
    sum_s2 = sample_pkg::sum_t'(prod_shift) + sample_pkg::sum_t'(offset_s1);
    if (sum_s2 > sample_pkg::sum_t'(sample_pkg::SAMPLE_MAX)) begin
      sat_s2 = sample_pkg::SAMPLE_MAX;   // clip high
    end else if (sum_s2 < sample_pkg::sum_t'(sample_pkg::SAMPLE_MIN)) begin
      sat_s2 = sample_pkg::SAMPLE_MIN;   // clip low
    end else begin
      sat_s2 = sample_pkg::sample_t'(sum_s2);
    end
  end

  always_ff @(posedge dest_clk) begin
    if (valid_s1) begin
      sample_out <= sat_s2;  // holds last result between strobes
    end
  end

  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      sample_out_valid <= 1'b0;
    end else begin
      sample_out_valid <= valid_s1;  // two cycles after sample_in_valid
    end
  end

endmodule

/* rtl/scaler_subsystem.sv */
// top level: config stream crossing, register bank and sample scaler

`timescale 1ns/1ps
module scaler_subsystem (
  input  logic                src_clk,
  input  logic                src_reset,
  input  cfg_pkg::cfg_word_t  cfg_data,
  input  logic                cfg_last,
  input  logic                cfg_valid,
  output logic                cfg_ready,

  input  logic                dest_clk,
  input  logic                dest_reset,
  input  sample_pkg::sample_t sample_in,
  input  logic                sample_in_valid,
  output sample_pkg::sample_t sample_out,
  output logic                sample_out_valid,
  output logic                config_update
);

  cfg_pkg::cfg_word_t  word_data;  // config word in dest_clk domain
  logic                word_last;
  logic                word_valid;
  logic                word_ready;
  sample_pkg::coef_t   gain;       // active config levels
  sample_pkg::sample_t offset;

  //////////////////////////////////////////////////
  // config path
  //////////////////////////////////////////////////

  axis_config_reg_cdc #(
    .DWIDTH(cfg_pkg::CFG_DWIDTH)
  ) cdc0 (
    .src_clk    (src_clk),
    .src_reset  (src_reset),
    .src_data   (cfg_data),
    .src_last   (cfg_last),
    .src_valid  (cfg_valid),
    .src_ready  (cfg_ready),
    .dest_clk   (dest_clk),
    .dest_reset (dest_reset),
    .dest_data  (word_data),
    .dest_last  (word_last),
    .dest_valid (word_valid),
    .dest_ready (word_ready)
  );

  config_reg_bank bank0 (
    .dest_clk      (dest_clk),
    .dest_reset    (dest_reset),
    .word_data     (word_data),
    .word_last     (word_last),
    .word_valid    (word_valid),
    .word_ready    (word_ready),
    .gain          (gain),
    .offset        (offset),
    .config_update (config_update)
  );

  //////////////////////////////////////////////////
  // sample path
  //////////////////////////////////////////////////

  sample_scaler scaler0 (
    .dest_clk         (dest_clk),
    .dest_reset       (dest_reset),
    .gain             (gain),
    .offset           (offset),
    .sample_in        (sample_in),
    .sample_in_valid  (sample_in_valid),
    .sample_out       (sample_out),
    .sample_out_valid (sample_out_valid)
  );

endmodule

/* test/scaler_subsystem_tb.sv */
// testbench for scaler_subsystem with clocks, reset and a table of tests applied in a loop
// bank and scaler reference model, compare tasks, monitors and timeout

`timescale 1ns/1ps
module scaler_subsystem_tb;

  localparam int          NUM_ROWS  = 6;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // galois taps of x^32+x^22+x^2+x+1

  logic                src_clk = 1'b0;
  logic                src_reset;
  cfg_pkg::cfg_word_t  cfg_data;
  logic                cfg_last;
  logic                cfg_valid;
  logic                cfg_ready;
  logic                dest_clk = 1'b0;
  logic                dest_reset;
  sample_pkg::sample_t sample_in;
  logic                sample_in_valid;
  sample_pkg::sample_t sample_out;
  logic                sample_out_valid;
  logic                config_update;

  //////////////////////////////////////////////////
  // test table with one row per test
  //////////////////////////////////////////////////

  string row_name [NUM_ROWS] = '{"reset_unity", "gain_offset", "clamp_high_low",
                                 "back_to_back", "gain_only", "neg_gain_clamp"};
  int    row_words [NUM_ROWS] = '{0, 2, 2, 2, 1, 2};    // words per packet
  int    row_burst [NUM_ROWS] = '{0, 1, 1, 3, 1, 1};    // packets sent back to back
  cfg_pkg::cfg_word_t row_gain [NUM_ROWS] =
    '{16'h0000, 16'h3000, 16'h7fff, 16'hd000, 16'h2000, 16'h8000};  // Q2.14
  cfg_pkg::cfg_word_t row_offset [NUM_ROWS] =
    '{16'h0000, 16'h0123, 16'h0040, 16'hff00, 16'h5555, 16'h7000};  // unused for 1 word
  int    row_samples [NUM_ROWS] = '{12, 16, 8, 12, 12, 8};
  logic  row_extreme [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};

  // fixed samples for the saturation rows
  sample_pkg::sample_t extreme_val [4] = '{16'sh7fff, 16'sh8000, 16'sh6000, 16'sha000};

  logic [31:0]         lfsr_state = 32'hedff;
  int                  cycle_count = 0;     // dest_clk edges since start
  int                  timeout_limit;
  int                  update_count = 0;    // config_update pulses seen
  logic                xfer_seen = 1'b0;    // word accepted on the previous src_clk edge
  int                  stall_count = 0;     // src edges with valid high, ready low
  int                  expected_updates = 0;
  string               cur_name = "reset";
  sample_pkg::sample_t exp_q [$];           // expected outputs in order
  int                  entry_q [$];         // cycle each sample entered

  // register bank model with active and shadow copies
  sample_pkg::coef_t   model_gain;
  sample_pkg::coef_t   model_shadow_gain;
  sample_pkg::sample_t model_offset;
  sample_pkg::sample_t model_shadow_offset;

  always #20 dest_clk = ~dest_clk;  // 40 ns
  always #13 src_clk  = ~src_clk;   // 26 ns period and unrelated to dest_clk

  scaler_subsystem dut0 (
    .src_clk          (src_clk),
    .src_reset        (src_reset),
    .cfg_data         (cfg_data),
    .cfg_last         (cfg_last),
    .cfg_valid        (cfg_valid),
    .cfg_ready        (cfg_ready),
    .dest_clk         (dest_clk),
    .dest_reset       (dest_reset),
    .sample_in        (sample_in),
    .sample_in_valid  (sample_in_valid),
    .sample_out       (sample_out),
    .sample_out_valid (sample_out_valid),
    .config_update    (config_update)
  );

  //////////////////////////////////////////////////
  // random bits and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end else begin
      return s >> 1;
    end
  endfunction

  function automatic logic [15:0] random_word();
    logic [15:0] v;
    v = '0;
    for (int b = 0; b < 16; b++) begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // floor of product / 2^14 for the Q2.14 gain, plus offset and clip to 16 bits
  function automatic sample_pkg::sample_t scale_model(input sample_pkg::sample_t s,
                                                      input sample_pkg::coef_t   g,
                                                      input sample_pkg::sample_t o);
    longint prod;
    longint sum;
    prod = longint'(s) * longint'(g);
    prod = prod >>> 14;                  // arithmetic shift floors toward -inf
    sum  = prod + longint'(o);
    if (sum > 64'sd32767) begin
      return sample_pkg::SAMPLE_MAX;
    end else if (sum < -64'sd32768) begin
      return sample_pkg::SAMPLE_MIN;
    end else begin
      return sample_pkg::sample_t'(sum);
    end
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_sample(input string name, input sample_pkg::sample_t expected,
                                input sample_pkg::sample_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  task automatic compare_int(input string name, input int expected, input int actual);
    if (actual != expected) begin
      fail_run($sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  // checks latency, value and strays on the output side and keeps the timeout
  always @(posedge dest_clk) begin
    int                  entry;
    sample_pkg::sample_t expected;
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      fail_run($sformatf("timeout: no finish after %0d dest_clk cycles", timeout_limit));
    end else begin
      if (config_update) update_count++;
      if (sample_out_valid) begin
        if (entry_q.size() == 0 || exp_q.size() == 0) begin
          fail_run("sample_out_valid arrived with no sample pending");
        end else begin
          entry    = entry_q.pop_front();
          expected = exp_q.pop_front();
          compare_int({cur_name, "_latency"}, 2, cycle_count - entry);
          compare_sample(cur_name, expected, sample_out);
        end
      end
      if (sample_in_valid) entry_q.push_back(cycle_count);  // edge the scaler takes it
    end
  end

  // host side handshake with one word in flight
  always @(posedge src_clk) begin
    if (xfer_seen && cfg_ready !== 1'b0) begin
      fail_run("cfg_ready was still high on the src_clk edge after a word was accepted");
    end
    xfer_seen = cfg_valid & cfg_ready;
    if (cfg_valid & ~cfg_ready) stall_count++;
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // starts on a src_clk edge and returns on the edge the word transfers
  task automatic send_word(input cfg_pkg::cfg_word_t data, input logic last);
    cfg_data  <= data;
    cfg_last  <= last;
    cfg_valid <= 1'b1;
    @(posedge src_clk);
    while (cfg_ready !== 1'b1) @(posedge src_clk);
  endtask

  // earlier packets of a burst step away from the row's final values
  task automatic send_config(input int r);
    cfg_pkg::cfg_word_t gw;
    cfg_pkg::cfg_word_t ow;
    int                 back;
    @(posedge src_clk);
    for (int k = 0; k < row_burst[r]; k++) begin
      back = row_burst[r] - 1 - k;
      gw   = row_gain[r] - cfg_pkg::cfg_word_t'(back * 1024);
      ow   = row_offset[r] - cfg_pkg::cfg_word_t'(back * 3);
      send_word(gw, row_words[r] == 1);
      model_shadow_gain = sample_pkg::coef_t'(gw);
      if (row_words[r] == 2) begin
        send_word(ow, 1'b1);
        model_shadow_offset = sample_pkg::sample_t'(ow);
      end
      model_gain   = model_shadow_gain;    // last word commits both
      model_offset = model_shadow_offset;
      expected_updates++;
    end
    cfg_valid <= 1'b0;  // valid was high across the whole burst
    cfg_last  <= 1'b0;
  endtask

  task automatic send_samples(input int r);
    sample_pkg::sample_t s;
    for (int i = 0; i < row_samples[r]; i++) begin
      @(posedge dest_clk);
      if (row_extreme[r]) begin
        s = extreme_val[i % 4];
      end else begin
        s = sample_pkg::sample_t'(random_word());
      end
      exp_q.push_back(scale_model(s, model_gain, model_offset));
      sample_in       <= s;
      sample_in_valid <= 1'b1;
      if (i % 4 == 3) begin  // idle gap after every fourth strobe
        @(posedge dest_clk);
        sample_in_valid <= 1'b0;
      end
    end
    @(posedge dest_clk);
    sample_in_valid <= 1'b0;
  endtask

  initial begin
    int total_samples;
    int base_stall;
    total_samples = 0;
    for (int r = 0; r < NUM_ROWS; r++) total_samples += row_samples[r];
    timeout_limit = 200 * NUM_ROWS + 100 * total_samples;

    src_reset           = 1'b1;
    dest_reset          = 1'b1;
    cfg_data            = '0;
    cfg_last            = 1'b0;
    cfg_valid           = 1'b0;
    sample_in           = '0;
    sample_in_valid     = 1'b0;
    model_gain          = sample_pkg::GAIN_RESET;   // bank comes up at unity gain
    model_shadow_gain   = sample_pkg::GAIN_RESET;
    model_offset        = sample_pkg::OFFSET_RESET;
    model_shadow_offset = sample_pkg::OFFSET_RESET;

    repeat (10) @(posedge dest_clk);
    dest_reset <= 1'b0;
    @(posedge src_clk);
    src_reset <= 1'b0;
    repeat (4) @(posedge dest_clk);

    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_name   = row_name[r];
      base_stall = stall_count;
      if (row_burst[r] > 0) begin
        send_config(r);
        @(posedge dest_clk);
        while (update_count < expected_updates) @(posedge dest_clk);
      end
      send_samples(r);
      while (exp_q.size() != 0) @(posedge dest_clk);
      compare_int({cur_name, "_updates"}, expected_updates, update_count);
      if (row_burst[r] > 1 && stall_count == base_stall) begin
        fail_run("cfg_ready never held off the host during back-to-back packets");
      end
    end

    repeat (4) @(posedge dest_clk);
    if (exp_q.size() == 0 && entry_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      fail_run("samples still pending at the end of the run");
    end
  end

endmodule

/* scaler_subsystem.f */
rtl/cfg_pkg.sv
rtl/sample_pkg.sv
rtl/cdc_handshake.sv
rtl/axis_config_reg_cdc.sv
rtl/config_reg_bank.sv
rtl/sample_scaler.sv
rtl/scaler_subsystem.sv
test/scaler_subsystem_tb.sv

/* Makefile */
# Verilator build and run of the scaler subsystem testbench
# the result is taken from the simulation log

TOP := scaler_subsystem_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -f scaler_subsystem.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" sim.log || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir sim.log
